//--- build.f
logic/cpuPkg.sv
logic/registerFile.sv
logic/busArbiter.sv
logic/alu.sv
logic/memoryUnit.sv
logic/controlSequencer.sv
logic/cpuDatapath.sv
verification/clockGen.sv
verification/cpuDatapathTb.sv

//--- verification/cpuDatapathTb.sv
// Self-checking testbench that loads a program into the CPU, runs it twice and checks RAM results
`default_nettype none

module cpuDatapathTb;
   timeunit 1ns;
   timeprecision 1ps;
   import cpuPkg::*;

   localparam int MemDepth   = 512;
   localparam int NumRows    = 18;
   localparam int ResultBase = 400;
   localparam int DataFirst  = 300;
   localparam int DataLast   = 331;
   localparam int LockedAddr = 450;

   logic        Clock;
   logic        reset;
   logic        run;
   logic        loadWrite;
   memAddress_t loadAddress;
   word_t       loadData;
   memAddress_t peekAddress;
   logic        busy;
   logic        halted;
   word_t       peekData;

   // Instruction rows, opcode with Ra, Rb and C
   opcode_t     rowOp [NumRows] = '{ADDI, ADDI, ORI, ANDI, ADDI, ADDI, LD, ADDI, LD,
                                    LD, ST, ST, ADDI, ANDI, ORI, ADDI, LD, ORI};
   regIndex_t   rowRa [NumRows] = '{1, 2, 4, 3, 0, 5, 6, 7, 8, 9, 4, 0, 10, 11, 12, 13, 14, 15};
   regIndex_t   rowRb [NumRows] = '{0, 1, 1, 4, 2, 0, 0, 0, 7, 7, 7, 0, 6, 8, 9, 13, 7, 1};
   logic [18:0] rowImm [NumRows] = '{19'h00025, 19'h7FFFD, 19'h40000, 19'h7FFFF, 19'd100,
                                     19'd7, 19'd305, 19'd300, 19'd9, 19'd15, 19'd22, 19'd320,
                                     19'd0, 19'd0, 19'd0, 19'd0, 19'd22, 19'd0};
   // Rows whose C comes from the random stream
   bit          rowRandom [NumRows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0,
                                        0, 0, 0, 1, 1, 1, 1, 0, 1};

   opcode_t     progOp [$];
   regIndex_t   progRa [$];
   regIndex_t   progRb [$];
   logic [18:0] progImm [$];

   // Reference model state, kept across runs like the DUT
   word_t modelReg [16];
   word_t modelMem [MemDepth];

   integer seed           = 32'h482a;
   int     checkCount     = 0;
   int     errorCount     = 0;
   int     cycleLimit     = 0;
   bit     waitingForHalt = 1'b0;

   clockGen #(
      .PeriodNs(40),
      .ResetCycles(2)
   ) u_clockGen (
      .Clock(Clock),
      .reset(reset)
   );

   cpuDatapath #(
      .MemDepth(MemDepth)
   ) u_cpuDatapath (
      .Clock(Clock), .reset(reset), .run(run),
      .loadWrite(loadWrite), .loadAddress(loadAddress), .loadData(loadData),
      .peekAddress(peekAddress), .busy(busy), .halted(halted), .peekData(peekData)
   );

   function automatic word_t encode(opcode_t op, regIndex_t ra, regIndex_t rb,
                                    logic [18:0] imm);
      return {op, ra, rb, imm};
   endfunction

   function automatic word_t signExtend(logic [18:0] imm);
      return {{13{imm[18]}}, imm};
   endfunction

   // Data pattern built from the full address
   function automatic word_t fillWord(int addr);
      return (32'h9E3779B9 * (addr + 1)) ^ word_t'(addr);
   endfunction

   task automatic checkValue(string name, word_t actual, word_t expected);
      checkCount++;
      assert (actual === expected) else begin
         $display("MISMATCH at %0t ns: %s expected %h actual %h",
                  $time, name, expected, actual);
         errorCount++;
      end
   endtask

   task automatic loadWord(int addr, word_t data);
      @(posedge Clock);
      loadWrite   <= 1'b1;
      loadAddress <= memAddress_t'(addr);
      loadData    <= data;
      @(posedge Clock);
      loadWrite   <= 1'b0;
   endtask

   // Peek data is registered, so read it half a cycle after the second edge
   task automatic peekWord(int addr, output word_t data);
      @(posedge Clock);
      peekAddress <= memAddress_t'(addr);
      @(posedge Clock);
      @(negedge Clock);
      data = peekData;
   endtask

   task automatic buildProgram();
      logic [18:0] imm;
      word_t       randomWord;
      for (int i = 0; i < NumRows; i++) begin
         imm = rowImm[i];
         if (rowRandom[i]) begin
            randomWord = $random(seed);
            imm        = randomWord[18:0];
         end
         progOp.push_back(rowOp[i]);
         progRa.push_back(rowRa[i]);
         progRb.push_back(rowRb[i]);
         progImm.push_back(imm);
      end
      // Dump R1..R15 with R0 as a zero base
      for (int r = 1; r < 16; r++) begin
         progOp.push_back(ST);
         progRa.push_back(regIndex_t'(r));
         progRb.push_back(4'd0);
         progImm.push_back(19'(ResultBase + r - 1));
      end
      progOp.push_back(HALT);
      progRa.push_back(4'd0);
      progRb.push_back(4'd0);
      progImm.push_back(19'd0);
   endtask

   task automatic loadMemory();
      word_t word;
      for (int i = 0; i < progOp.size(); i++) begin
         word = encode(progOp[i], progRa[i], progRb[i], progImm[i]);
         loadWord(i, word);
         modelMem[i] = word;
      end
      for (int addr = DataFirst; addr <= DataLast; addr++) begin
         loadWord(addr, fillWord(addr));
         modelMem[addr] = fillWord(addr);
      end
      loadWord(LockedAddr, fillWord(LockedAddr));
      modelMem[LockedAddr] = fillWord(LockedAddr);
   endtask

   // Executes the program up to HALT by the instruction rules
   task automatic executeModel();
      word_t base;
      word_t imm;
      word_t ea;
      int    pc;
      pc = 0;
      while (pc < progOp.size() && progOp[pc] != HALT) begin
         base = (progRb[pc] == 4'd0) ? 32'd0 : modelReg[progRb[pc]];
         imm  = signExtend(progImm[pc]);
         ea   = base + imm;
         case (progOp[pc])
            ADDI: modelReg[progRa[pc]] = ea;
            ANDI: modelReg[progRa[pc]] = base & imm;
            ORI:  modelReg[progRa[pc]] = base | imm;
            LD:   modelReg[progRa[pc]] = modelMem[ea[8:0]];
            ST:   modelMem[ea[8:0]] = modelReg[progRa[pc]];
            default: ;
         endcase
         pc++;
      end
   endtask

   task automatic runProgram();
      @(posedge Clock);
      run <= 1'b1;
      @(posedge Clock);
      run <= 1'b0;
      waitingForHalt = 1'b1;
      @(negedge Clock);
      checkValue("busy", busy, 32'd1);
      checkValue("halted", halted, 32'd0);
      // Attempted load while the program runs
      loadWord(LockedAddr, 32'hBAD001C2);
      while (!halted) @(negedge Clock);
      waitingForHalt = 1'b0;
      checkValue("busy", busy, 32'd0);
   endtask

   task automatic compareMemory();
      word_t actual;
      for (int addr = DataFirst; addr <= DataLast; addr++) begin
         peekWord(addr, actual);
         checkValue($sformatf("peekData[%0d]", addr), actual, modelMem[addr]);
      end
      for (int addr = ResultBase; addr < ResultBase + 15; addr++) begin
         peekWord(addr, actual);
         checkValue($sformatf("peekData[%0d]", addr), actual, modelMem[addr]);
      end
   endtask

   task automatic reportTest(string name, int checksBefore, int errorsBefore);
      $display("%s: %0d checks, %0d errors", name,
               checkCount - checksBefore, errorCount - errorsBefore);
   endtask

   initial begin : mainSequence
      word_t actual;
      int    checksBefore;
      int    errorsBefore;
      run         = 1'b0;
      loadWrite   = 1'b0;
      loadAddress = '0;
      loadData    = '0;
      peekAddress = '0;
      for (int r = 0; r < 16; r++) begin
         modelReg[r] = '0;
      end
      buildProgram();
      cycleLimit = 8 * progOp.size() + 100;
      @(negedge Clock);
      while (reset) @(negedge Clock);

      checksBefore = checkCount;
      errorsBefore = errorCount;
      checkValue("busy", busy, 32'd0);
      checkValue("halted", halted, 32'd0);
      loadWord(500, 32'h5A5AC3F4);
      peekWord(500, actual);
      checkValue("peekData[500]", actual, 32'h5A5AC3F4);
      reportTest("reset and load port", checksBefore, errorsBefore);

      loadMemory();

      checksBefore = checkCount;
      errorsBefore = errorCount;
      runProgram();
      executeModel();
      compareMemory();
      reportTest("first run", checksBefore, errorsBefore);

      checksBefore = checkCount;
      errorsBefore = errorCount;
      peekWord(LockedAddr, actual);
      checkValue($sformatf("peekData[%0d]", LockedAddr), actual, modelMem[LockedAddr]);
      reportTest("load lockout while busy", checksBefore, errorsBefore);

      // Registers carry over, so the model continues from its current state
      checksBefore = checkCount;
      errorsBefore = errorCount;
      runProgram();
      executeModel();
      compareMemory();
      reportTest("second run", checksBefore, errorsBefore);

      $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Counts cycles spent waiting for halted in each run
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= cycleLimit) begin
         @(posedge Clock);
         if (waitingForHalt) begin
            cycles++;
         end else begin
            cycles = 0;
         end
      end
      $display("Timeout: halted did not rise within %0d cycles of run", cycleLimit);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/clockGen.sv
// Testbench clock and reset source for the CPU datapath, instantiated once by the testbench top
`default_nettype none

module clockGen #(
   parameter int PeriodNs    = 40,
   parameter int ResetCycles = 2
) (
   output logic Clock,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      Clock = 1'b0;
      forever #(PeriodNs / 2) Clock = ~Clock;
   end

   // Reset held over the first rising edges
   initial begin
      reset = 1'b1;
      repeat (ResetCycles) @(posedge Clock);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

//--- logic/cpuDatapath.sv
// Top level of the single-bus CPU, joining sequencer, registers, ALU and memory on one bus
`default_nettype none

module cpuDatapath #(
   parameter int MemDepth = 512
) (
   input  wire logic                 Clock,
   input  wire logic                 reset,
   input  wire logic                 run,
   input  wire logic                 loadWrite,
   input  wire cpuPkg::memAddress_t  loadAddress,
   input  wire cpuPkg::word_t        loadData,
   input  wire cpuPkg::memAddress_t  peekAddress,
   output logic                      busy,
   output logic                      halted,
   output cpuPkg::word_t             peekData
);
   import cpuPkg::*;

   // Shared bus and the values offered to it
   word_t     bus;
   word_t     pcValue;
   word_t     immValue;
   word_t     mdrValue;
   word_t     zValue;
   word_t     regValue;

   regIndex_t raField;
   regIndex_t rbField;
   aluOp_t    aluOp;

   logic pcOut;
   logic mdrOut;
   logic zOut;
   logic rOut;
   logic immOut;
   logic marIn;
   logic mdrIn;
   logic irIn;
   logic yIn;
   logic zIn;
   logic rIn;
   logic gra;
   logic grb;
   logic baOut;
   logic read;
   logic write;

   controlSequencer u_controlSequencer (
      .Clock(Clock), .reset(reset), .bus(bus), .run(run),
      .pcValue(pcValue), .immValue(immValue), .raField(raField), .rbField(rbField),
      .pcOut(pcOut), .mdrOut(mdrOut), .zOut(zOut), .rOut(rOut), .immOut(immOut),
      .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn), .yIn(yIn), .zIn(zIn), .rIn(rIn),
      .gra(gra), .grb(grb), .baOut(baOut), .read(read), .write(write),
      .aluOp(aluOp), .busy(busy), .halted(halted)
   );

   busArbiter u_busArbiter (
      .pcValue(pcValue), .mdrValue(mdrValue), .zValue(zValue),
      .regValue(regValue), .immValue(immValue),
      .pcOut(pcOut), .mdrOut(mdrOut), .zOut(zOut), .rOut(rOut), .immOut(immOut),
      .bus(bus)
   );

   registerFile u_registerFile (
      .Clock(Clock), .reset(reset), .bus(bus),
      .raField(raField), .rbField(rbField), .gra(gra), .grb(grb),
      .rIn(rIn), .rOut(rOut), .baOut(baOut), .regOut(regValue)
   );

   alu u_alu (
      .Clock(Clock), .reset(reset), .bus(bus),
      .yIn(yIn), .zIn(zIn), .aluOp(aluOp), .zValue(zValue)
   );

   // External load port is locked out while the program runs
   memoryUnit #(
      .MemDepth(MemDepth)
   ) u_memoryUnit (
      .Clock(Clock), .reset(reset), .bus(bus),
      .marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write), .busy(busy),
      .loadWrite(loadWrite), .loadAddress(loadAddress), .loadData(loadData),
      .peekAddress(peekAddress), .mdrValue(mdrValue), .peekData(peekData)
   );

endmodule

`default_nettype wire

//--- logic/controlSequencer.sv
// Hardwired control unit holding PC and IR, stepping T0..T7 and issuing all datapath strobes
`default_nettype none

module controlSequencer (
   input  wire logic           Clock,
   input  wire logic           reset,
   input  wire cpuPkg::word_t  bus,
   input  wire logic           run,
   output cpuPkg::word_t       pcValue,
   output cpuPkg::word_t       immValue,
   output cpuPkg::regIndex_t   raField,
   output cpuPkg::regIndex_t   rbField,
   output logic                pcOut,
   output logic                mdrOut,
   output logic                zOut,
   output logic                rOut,
   output logic                immOut,
   output logic                marIn,
   output logic                mdrIn,
   output logic                irIn,
   output logic                yIn,
   output logic                zIn,
   output logic                rIn,
   output logic                gra,
   output logic                grb,
   output logic                baOut,
   output logic                read,
   output logic                write,
   output cpuPkg::aluOp_t      aluOp,
   output logic                busy,
   output logic                halted
);
   import cpuPkg::*;

   step_t   state;
   word_t   ir;
   opcode_t opcode;
   opcode_t fetchedOpcode;
   logic    memOp;
   logic    stopFetched;

   assign opcode        = opcode_t'(ir[OpcodeMsb:OpcodeLsb]);
   assign raField       = ir[RaMsb:RaLsb];
   assign rbField       = ir[RbMsb:RbLsb];
   assign immValue      = {{(31 - ImmMsb + ImmLsb){ir[ImmMsb]}}, ir[ImmMsb:ImmLsb]};
   assign memOp         = opcode inside {LD, ST};

   // Decode happens in T2 while the instruction is still on the bus
   // Unknown opcodes stop the machine like HALT
   assign fetchedOpcode = opcode_t'(bus[OpcodeMsb:OpcodeLsb]);
   assign stopFetched   = !(fetchedOpcode inside {LD, ST, ADDI, ANDI, ORI});

   always_ff @(posedge Clock) begin
      if (reset) begin
         state   <= IDLE;
         pcValue <= '0;
         ir      <= '0;
         busy    <= 1'b0;
         halted  <= 1'b0;
      end else begin
         if (irIn) begin
            ir <= bus;
         end
         unique case (state)
            IDLE, STOPPED: begin
               if (run) begin
                  state   <= T0;
                  pcValue <= '0;
                  busy    <= 1'b1;
                  halted  <= 1'b0;
               end
            end
            T0: begin
               pcValue <= pcValue + 32'd1;
               state   <= T1;
            end
            T1: state <= T2;
            T2: begin
               if (stopFetched) begin
                  state  <= STOPPED;
                  busy   <= 1'b0;
                  halted <= 1'b1;
               end else begin
                  state <= T3;
               end
            end
            T3: state <= T4;
            T4: state <= T5;
            T5: state <= memOp ? T6 : T0;
            T6: state <= T7;
            T7: state <= T0;
            default: state <= IDLE;
         endcase
      end
   end

   // Strobe pattern per step
   always_comb begin
      pcOut  = 1'b0;
      mdrOut = 1'b0;
      zOut   = 1'b0;
      rOut   = 1'b0;
      immOut = 1'b0;
      marIn  = 1'b0;
      mdrIn  = 1'b0;
      irIn   = 1'b0;
      yIn    = 1'b0;
      zIn    = 1'b0;
      rIn    = 1'b0;
      gra    = 1'b0;
      grb    = 1'b0;
      baOut  = 1'b0;
      read   = 1'b0;
      write  = 1'b0;
      aluOp  = ADD;
      unique case (state)
         T0: begin
            pcOut = 1'b1;
            marIn = 1'b1;
         end
         T1: read = 1'b1;
         T2: begin
            mdrOut = 1'b1;
            irIn   = 1'b1;
         end
         // Base operand into Y
         T3: begin
            rOut  = 1'b1;
            grb   = 1'b1;
            baOut = 1'b1;
            yIn   = 1'b1;
         end
         T4: begin
            immOut = 1'b1;
            zIn    = 1'b1;
            if (opcode == ANDI) begin
               aluOp = AND;
            end else if (opcode == ORI) begin
               aluOp = OR;
            end
         end
         T5: begin
            zOut = 1'b1;
            if (memOp) begin
               marIn = 1'b1;
            end else begin
               gra = 1'b1;
               rIn = 1'b1;
            end
         end
         T6: begin
            if (opcode == ST) begin
               rOut  = 1'b1;
               gra   = 1'b1;
               mdrIn = 1'b1;
            end else begin
               read = 1'b1;
            end
         end
         T7: begin
            if (opcode == ST) begin
               write = 1'b1;
            end else begin
               mdrOut = 1'b1;
               gra    = 1'b1;
               rIn    = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/memoryUnit.sv
// MAR, MDR and word RAM of the datapath, with an external load port and a peek read port
`default_nettype none

module memoryUnit #(
   parameter int MemDepth = 512
) (
   input  wire logic                 Clock,
   input  wire logic                 reset,
   input  wire cpuPkg::word_t        bus,
   input  wire logic                 marIn,
   input  wire logic                 mdrIn,
   input  wire logic                 read,
   input  wire logic                 write,
   input  wire logic                 busy,
   input  wire logic                 loadWrite,
   input  wire cpuPkg::memAddress_t  loadAddress,
   input  wire cpuPkg::word_t        loadData,
   input  wire cpuPkg::memAddress_t  peekAddress,
   output cpuPkg::word_t             mdrValue,
   output cpuPkg::word_t             peekData
);
   import cpuPkg::*;

   word_t       ram [MemDepth];
   memAddress_t mar;
   logic        ramWrite;
   memAddress_t ramAddress;
   word_t       ramData;

   // One write port shared by the CPU and the load port
   // The CPU only writes while busy, so the two never collide
   always_comb begin
      ramWrite   = 1'b0;
      ramAddress = mar;
      ramData    = mdrValue;
      if (write) begin
         ramWrite = 1'b1;
      end else if (loadWrite && !busy) begin
         ramWrite   = 1'b1;
         ramAddress = loadAddress;
         ramData    = loadData;
      end
   end

   always_ff @(posedge Clock) begin
      if (ramWrite) begin
         ram[ramAddress] <= ramData;
      end
   end

   // Peek port, valid one cycle after the address
   always_ff @(posedge Clock) begin
      peekData <= ram[peekAddress];
   end

   // MAR keeps the low address bits of the bus
   always_ff @(posedge Clock) begin
      if (reset) begin
         mar      <= '0;
         mdrValue <= '0;
      end else begin
         if (marIn) begin
            mar <= memAddress_t'(bus);
         end
         if (mdrIn) begin
            mdrValue <= bus;
         end else if (read) begin
            mdrValue <= ram[mar];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/alu.sv
// ALU with its Y operand register and Z result register, fed and drained through the bus
`default_nettype none

module alu (
   input  wire logic             Clock,
   input  wire logic             reset,
   input  wire cpuPkg::word_t    bus,
   input  wire logic             yIn,
   input  wire logic             zIn,
   input  wire cpuPkg::aluOp_t   aluOp,
   output cpuPkg::word_t         zValue
);
   import cpuPkg::*;

   word_t yValue;
   word_t result;

   // Second operand comes straight off the bus
   always_comb begin
      unique case (aluOp)
         AND:     result = yValue & bus;
         OR:      result = yValue | bus;
         default: result = yValue + bus;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         yValue <= '0;
         zValue <= '0;
      end else begin
         if (yIn) begin
            yValue <= bus;
         end
         if (zIn) begin
            zValue <= result;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/busArbiter.sv
// Resolves which peer drives the shared bus each cycle, by fixed priority on the out-enables
`default_nettype none

module busArbiter (
   input  wire cpuPkg::word_t  pcValue,
   input  wire cpuPkg::word_t  mdrValue,
   input  wire cpuPkg::word_t  zValue,
   input  wire cpuPkg::word_t  regValue,
   input  wire cpuPkg::word_t  immValue,
   input  wire logic           pcOut,
   input  wire logic           mdrOut,
   input  wire logic           zOut,
   input  wire logic           rOut,
   input  wire logic           immOut,
   output cpuPkg::word_t       bus
);

   // Priority order is MDR, Z, register file, PC, immediate
   always_comb begin
      if (mdrOut) begin
         bus = mdrValue;
      end else if (zOut) begin
         bus = zValue;
      end else if (rOut) begin
         bus = regValue;
      end else if (pcOut) begin
         bus = pcValue;
      end else if (immOut) begin
         bus = immValue;
      end else begin
         // Idle bus
         bus = '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
// Sixteen general registers on the shared bus, addressed through the Ra/Rb fields of the IR
`default_nettype none

module registerFile (
   input  wire logic               Clock,
   input  wire logic               reset,
   input  wire cpuPkg::word_t      bus,
   input  wire cpuPkg::regIndex_t  raField,
   input  wire cpuPkg::regIndex_t  rbField,
   input  wire logic               gra,
   input  wire logic               grb,
   input  wire logic               rIn,
   input  wire logic               rOut,
   input  wire logic               baOut,
   output cpuPkg::word_t           regOut
);
   import cpuPkg::*;

   word_t     regs [16];
   regIndex_t selIndex;

   // Gra wins if both selects are raised
   always_comb begin
      if (gra) begin
         selIndex = raField;
      end else if (grb) begin
         selIndex = rbField;
      end else begin
         selIndex = '0;
      end
   end

   // R0 reads as zero only when used as a base address
   always_comb begin
      regOut = '0;
      if (rOut && !(baOut && selIndex == '0)) begin
         regOut = regs[selIndex];
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (rIn) begin
         regs[selIndex] <= bus;
      end
   end

endmodule

`default_nettype wire

//--- logic/cpuPkg.sv
// Shared types, encodings and instruction field positions, imported by every datapath block
`default_nettype none

package cpuPkg;

   // One bus or register word
   typedef logic [31:0] word_t;

   // Register number from an instruction field
   typedef logic [3:0] regIndex_t;

   // Memory word address, sized for the default depth of 512 words
   typedef logic [8:0] memAddress_t;

   // Instruction opcodes in bits 31..27
   typedef enum logic [4:0] {
      LD   = 5'd0,
      ST   = 5'd1,
      ADDI = 5'd2,
      ANDI = 5'd3,
      ORI  = 5'd4,
      HALT = 5'd5
   } opcode_t;

   // Sequencer steps, one clock each
   typedef enum logic [3:0] {
      IDLE,
      T0,
      T1,
      T2,
      T3,
      T4,
      T5,
      T6,
      T7,
      STOPPED
   } step_t;

   typedef enum logic [1:0] {
      ADD,
      AND,
      OR
   } aluOp_t;

   // Instruction field positions
   localparam int OpcodeMsb = 31;
   localparam int OpcodeLsb = 27;
   localparam int RaMsb     = 26;
   localparam int RaLsb     = 23;
   localparam int RbMsb     = 22;
   localparam int RbLsb     = 19;
   // Constant C, sign-extended to a full word
   localparam int ImmMsb    = 18;
   localparam int ImmLsb    = 0;

endpackage

`default_nettype wire
